// ==== src/tlb_entry_array.sv ====
module tlb_entry_array (
    input  logic                aclk,
    input  logic                arst_n,
    // write port shared by tlbwr and tlbfill
    input  logic                we,
    input  tlb_pkg::tlb_idx_t   w_index,
    input  tlb_pkg::tlb_entry_t w_entry,
    // per-entry invalidation
    input  tlb_pkg::tlb_mask_t  clear_mask,
    // read port
    input  tlb_pkg::tlb_idx_t   r_index,
    output tlb_pkg::tlb_entry_t r_entry,
    // whole array for the search ports and invtlb
    output tlb_pkg::tlb_entry_t entries [tlb_pkg::TLBNUM]
);
    import tlb_pkg::*;

    tlb_mask_t  e_q;
    tlb_entry_t store_q [TLBNUM];

    // clear first so a same-cycle write wins its own index
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= '0;
        end else begin
            e_q <= e_q & ~clear_mask;
            if (we) begin
                e_q[w_index] <= w_entry.e;
            end
        end
    end

    // entry payload
    always_ff @(posedge aclk) begin
        if (we) begin
            store_q[w_index] <= w_entry;
        end
    end

    // e always comes from the valid register
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            entries[i]   = store_q[i];
            entries[i].e = e_q[i];
        end
    end

    assign r_entry = entries[r_index];

endmodule

// ==== src/tlb_maint_ctrl.sv ====
module tlb_maint_ctrl (
    input  logic                invtlb_valid,
    input  tlb_pkg::invtlb_op_t invtlb_op,
    input  tlb_pkg::asid_t      inv_asid,
    input  tlb_pkg::vppn_t      inv_vppn,
    input  tlb_pkg::tlb_entry_t entries [tlb_pkg::TLBNUM],
    output tlb_pkg::tlb_mask_t  clear_mask
);
    import tlb_pkg::*;

    tlb_mask_t g_set;
    tlb_mask_t asid_hit;
    tlb_mask_t va_hit;
    tlb_mask_t op_sel;

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            g_set[i]    = entries[i].g;
            asid_hit[i] = entries[i].asid == inv_asid;
            va_hit[i]   = vppn_match(entries[i].vppn, entries[i].ps, inv_vppn);
        end
    end

    // entries the op selects regardless of valid
    always_comb begin
        case (invtlb_op)
            INV_ALL0,
            INV_ALL1:         op_sel = '1;
            INV_G1:           op_sel = g_set;
            INV_G0:           op_sel = ~g_set;
            INV_G0_ASID:      op_sel = ~g_set & asid_hit;
            INV_G0_ASID_VA:   op_sel = ~g_set & asid_hit & va_hit;
            INV_ASID_OR_G_VA: op_sel = (g_set | asid_hit) & va_hit;
            // reserved ops leave the array alone
            default:          op_sel = '0;
        endcase
    end

    // only live entries need clearing
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            clear_mask[i] = invtlb_valid && entries[i].e && op_sel[i];
        end
    end

endmodule

// ==== src/tlb_pkg.sv ====
package tlb_pkg;

    localparam int TLBNUM   = 16;
    localparam int TLBIDX_W = $clog2(TLBNUM);

    typedef logic [TLBIDX_W-1:0] tlb_idx_t;
    typedef logic [18:0]         vppn_t;
    typedef logic [9:0]          asid_t;
    typedef logic [19:0]         ppn_t;
    typedef logic [5:0]          ps_t;
    typedef logic [1:0]          plv_t;
    typedef logic [1:0]          mat_t;
    typedef logic [TLBNUM-1:0]   tlb_mask_t;
    typedef logic [4:0]          invtlb_op_t;

    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_4M = 6'd21;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    // invtlb op codes
    localparam invtlb_op_t INV_ALL0         = 5'd0;
    localparam invtlb_op_t INV_ALL1         = 5'd1;
    localparam invtlb_op_t INV_G1           = 5'd2;
    localparam invtlb_op_t INV_G0           = 5'd3;
    localparam invtlb_op_t INV_G0_ASID      = 5'd4;
    localparam invtlb_op_t INV_G0_ASID_VA   = 5'd5;
    localparam invtlb_op_t INV_ASID_OR_G_VA = 5'd6;

    // a 4M page pair ignores vppn[8:0] in the compare
    function automatic logic vppn_match(vppn_t entry_vppn, ps_t entry_ps, vppn_t req_vppn);
        case (entry_ps)
            PS_4K:   return entry_vppn == req_vppn;
            PS_4M:   return entry_vppn[18:9] == req_vppn[18:9];
            // unsupported page sizes never match
            default: return 1'b0;
        endcase
    endfunction

endpackage

// ==== src/tlb_search.sv ====
module tlb_search (
    input  tlb_pkg::vppn_t      vppn,
    input  logic                va_bit12,
    input  tlb_pkg::asid_t      asid,
    input  tlb_pkg::tlb_entry_t entries [tlb_pkg::TLBNUM],
    output logic                found,
    output tlb_pkg::tlb_idx_t   index,
    output tlb_pkg::tlb_page_t  page,
    output tlb_pkg::ps_t        ps
);
    import tlb_pkg::*;

    tlb_mask_t  hit;
    tlb_idx_t   hit_idx;
    tlb_entry_t hit_entry;
    logic       odd_page;

    // per-entry compare
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            hit[i] = entries[i].e
                     && (entries[i].g || (entries[i].asid == asid))
                     && vppn_match(entries[i].vppn, entries[i].ps, vppn);
        end
    end

    // lowest index wins on multiple hits
    always_comb begin
        hit_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign found     = |hit;
    assign hit_entry = entries[hit_idx];

    // odd page bit sits just above the page offset
    assign odd_page = (hit_entry.ps == PS_4M) ? vppn[8] : va_bit12;

    always_comb begin
        if (found) begin
            index = hit_idx;
            ps    = hit_entry.ps;
            page  = odd_page ? hit_entry.page1 : hit_entry.page0;
        end else begin
            index = '0;
            ps    = '0;
            page  = '0;
        end
    end

endmodule

// ==== src/tlb_top.sv ====
module tlb_top (
    input  logic                aclk,
    input  logic                arst_n,
    // search port 0 for fetch
    input  tlb_pkg::vppn_t      s0_vppn,
    input  logic                s0_va_bit12,
    input  tlb_pkg::asid_t      s0_asid,
    output logic                s0_found,
    output tlb_pkg::tlb_idx_t   s0_index,
    output tlb_pkg::tlb_page_t  s0_page,
    output tlb_pkg::ps_t        s0_ps,
    // search port 1 for load/store
    input  tlb_pkg::vppn_t      s1_vppn,
    input  logic                s1_va_bit12,
    input  tlb_pkg::asid_t      s1_asid,
    output logic                s1_found,
    output tlb_pkg::tlb_idx_t   s1_index,
    output tlb_pkg::tlb_page_t  s1_page,
    output tlb_pkg::ps_t        s1_ps,
    // write port
    input  logic                we,
    input  tlb_pkg::tlb_idx_t   w_index,
    input  tlb_pkg::tlb_entry_t w_entry,
    // read port
    input  tlb_pkg::tlb_idx_t   r_index,
    output tlb_pkg::tlb_entry_t r_entry,
    // invtlb
    input  logic                invtlb_valid,
    input  tlb_pkg::invtlb_op_t invtlb_op,
    input  tlb_pkg::asid_t      inv_asid,
    input  tlb_pkg::vppn_t      inv_vppn
);
    import tlb_pkg::*;

    tlb_entry_t entries [TLBNUM];
    tlb_mask_t  clear_mask;

    tlb_entry_array u_entry_array (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .we         (we),
        .w_index    (w_index),
        .w_entry    (w_entry),
        .clear_mask (clear_mask),
        .r_index    (r_index),
        .r_entry    (r_entry),
        .entries    (entries)
    );

    tlb_maint_ctrl u_maint_ctrl (
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .inv_asid     (inv_asid),
        .inv_vppn     (inv_vppn),
        .entries      (entries),
        .clear_mask   (clear_mask)
    );

    tlb_search u_s0 (
        .vppn     (s0_vppn),
        .va_bit12 (s0_va_bit12),
        .asid     (s0_asid),
        .entries  (entries),
        .found    (s0_found),
        .index    (s0_index),
        .page     (s0_page),
        .ps       (s0_ps)
    );

    tlb_search u_s1 (
        .vppn     (s1_vppn),
        .va_bit12 (s1_va_bit12),
        .asid     (s1_asid),
        .entries  (entries),
        .found    (s1_found),
        .index    (s1_index),
        .page     (s1_page),
        .ps       (s1_ps)
    );

endmodule

// ==== tests/tlb_model.svh ====
`ifndef TLB_MODEL_SVH
`define TLB_MODEL_SVH

// mirror of the TLB as of the last rising edge
tlb_entry_t model_tlb [TLBNUM];
tlb_mask_t  model_written;

function automatic void model_reset();
    for (int i = 0; i < TLBNUM; i++) begin
        model_tlb[i] = '0;
    end
    model_written = '0;
endfunction

// 4M pages only compare vppn[18:9]
function automatic logic model_page_hit(input tlb_entry_t ent, input vppn_t va);
    if (ent.ps == 6'd21) begin
        return ent.vppn[18:9] == va[18:9];
    end
    return ent.vppn == va;
endfunction

function automatic void ref_search(input vppn_t va, input logic b12, input asid_t as,
                                   output logic found, output tlb_idx_t idx,
                                   output tlb_page_t pg, output ps_t ps);
    logic odd;
    found = 1'b0;
    idx   = '0;
    pg    = '0;
    ps    = '0;
    for (int i = 0; i < TLBNUM; i++) begin
        if (!found && model_tlb[i].e && (model_tlb[i].g || model_tlb[i].asid == as)
                && model_page_hit(model_tlb[i], va)) begin
            found = 1'b1;
            idx   = tlb_idx_t'(i);
            ps    = model_tlb[i].ps;
            odd   = (model_tlb[i].ps == 6'd21) ? va[8] : b12;
            pg    = odd ? model_tlb[i].page1 : model_tlb[i].page0;
        end
    end
endfunction

function automatic tlb_entry_t ref_read(input tlb_idx_t idx);
    return model_tlb[idx];
endfunction

function automatic tlb_mask_t ref_inv_mask(input logic valid, input invtlb_op_t op,
                                           input asid_t as, input vppn_t va);
    tlb_mask_t mask;
    logic      g;
    logic      am;
    logic      vm;
    logic      sel;
    mask = '0;
    for (int i = 0; i < TLBNUM; i++) begin
        g  = model_tlb[i].g;
        am = model_tlb[i].asid == as;
        vm = model_page_hit(model_tlb[i], va);
        case (op)
            5'd0, 5'd1: sel = 1'b1;
            5'd2:       sel = g;
            5'd3:       sel = !g;
            5'd4:       sel = !g && am;
            5'd5:       sel = !g && am && vm;
            5'd6:       sel = (g || am) && vm;
            default:    sel = 1'b0;
        endcase
        mask[i] = valid && model_tlb[i].e && sel;
    end
    return mask;
endfunction

// clear first, then the write owns its index
function automatic void model_step(input logic wr, input tlb_idx_t idx,
                                   input tlb_entry_t ent, input tlb_mask_t clr);
    for (int i = 0; i < TLBNUM; i++) begin
        if (clr[i]) begin
            model_tlb[i].e = 1'b0;
        end
    end
    if (wr) begin
        model_tlb[idx]     = ent;
        model_written[idx] = 1'b1;
    end
endfunction

`endif

// ==== tests/tlb_top_tb.sv ====
module tlb_top_tb;
    import tlb_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic       aclk = 1'b0;
    logic       arst_n;
    vppn_t      s0_vppn, s1_vppn, inv_vppn;
    logic       s0_va_bit12, s1_va_bit12, s0_found, s1_found;
    asid_t      s0_asid, s1_asid, inv_asid;
    tlb_idx_t   s0_index, s1_index, w_index, r_index;
    tlb_page_t  s0_page, s1_page;
    ps_t        s0_ps, s1_ps;
    logic       we, invtlb_valid;
    tlb_entry_t w_entry, r_entry;
    invtlb_op_t invtlb_op;

    int   errors;
    int   checks;
    logic check_en;

    `include "tlb_model.svh"

    tlb_top tlb_top_inst (.*);

    initial begin
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (!arst_n) begin
            model_reset();
        end else begin
            model_step(we, w_index, w_entry,
                       ref_inv_mask(invtlb_valid, invtlb_op, inv_asid, inv_vppn));
        end
    end

    task automatic wait_falls(input int n);
        bit timed_out;
        timed_out = 1'b0;
        fork
            repeat (n) @(negedge aclk);
            begin
                #(CLK_PERIOD * (n + 2));
                timed_out = 1'b1;
            end
        join_any
        disable fork;
        if (timed_out) begin
            $display("clock stalled, no falling edge within %0d cycles", n + 2);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [88:0] got,
                                   input logic [88:0] exp);
        errors++;
        $display("CHECK FAILED %s: got %0h, expected %0h", name, got, exp);
    endtask

    task automatic check_search(input string port, input logic found, input logic exp_found,
                                input tlb_idx_t idx, input tlb_idx_t exp_idx,
                                input tlb_page_t page, input tlb_page_t exp_page,
                                input ps_t ps, input ps_t exp_ps);
        checks++;
        if (found !== exp_found) report_mismatch({port, "_found"}, found, exp_found);
        if (idx !== exp_idx) report_mismatch({port, "_index"}, idx, exp_idx);
        if (page !== exp_page) report_mismatch({port, "_page"}, page, exp_page);
        if (ps !== exp_ps) report_mismatch({port, "_ps"}, ps, exp_ps);
    endtask

    // unwritten slots only have a defined e bit
    task automatic check_entry(input tlb_entry_t got, input tlb_entry_t exp, input logic full);
        checks++;
        if (full && got !== exp) begin
            report_mismatch("r_entry", got, exp);
        end else if (!full && got.e !== exp.e) begin
            report_mismatch("r_entry.e", got.e, exp.e);
        end
    endtask

    // compare just before each rising edge
    initial begin
        logic      e_found;
        tlb_idx_t  e_idx;
        tlb_page_t e_page;
        ps_t       e_ps;
        forever begin
            wait_falls(1);
            #(CLK_PERIOD / 4);
            if (check_en) begin
                ref_search(s0_vppn, s0_va_bit12, s0_asid, e_found, e_idx, e_page, e_ps);
                check_search("s0", s0_found, e_found, s0_index, e_idx, s0_page, e_page,
                             s0_ps, e_ps);
                ref_search(s1_vppn, s1_va_bit12, s1_asid, e_found, e_idx, e_page, e_ps);
                check_search("s1", s1_found, e_found, s1_index, e_idx, s1_page, e_page,
                             s1_ps, e_ps);
                check_entry(r_entry, ref_read(r_index), model_written[r_index]);
            end
        end
    end

    function automatic ps_t rand_ps();
        return $urandom_range(0, 1) ? PS_4M : PS_4K;
    endfunction

    // small asid and vppn pools so invalidates find matches
    function automatic tlb_entry_t rand_entry(input ps_t ps);
        logic [95:0] bits;
        tlb_entry_t  ent;
        bits           = {$urandom, $urandom, $urandom};
        ent            = bits[88:0];
        ent.e          = 1'b1;
        ent.ps         = ps;
        ent.asid       = asid_t'($urandom_range(0, 3));
        ent.vppn[18:9] = 10'($urandom_range(0, 3));
        return ent;
    endfunction

    task automatic drive_search(input vppn_t va, input logic b12, input asid_t as);
        s0_vppn     = va;
        s0_va_bit12 = b12;
        s0_asid     = as;
        s1_vppn     = va;
        s1_va_bit12 = b12;
        s1_asid     = as;
    endtask

    task automatic search_both(input vppn_t va, input logic b12, input asid_t as);
        drive_search(va, b12, as);
        wait_falls(1);
    endtask

    task automatic write_entry(input tlb_idx_t idx, input tlb_entry_t ent);
        we      = 1'b1;
        w_index = idx;
        w_entry = ent;
        wait_falls(1);
        we = 1'b0;
    endtask

    task automatic invalidate(input invtlb_op_t op, input asid_t as, input vppn_t va);
        invtlb_valid = 1'b1;
        invtlb_op    = op;
        inv_asid     = as;
        inv_vppn     = va;
        wait_falls(1);
        invtlb_valid = 1'b0;
    endtask

    task automatic fill_all();
        for (int i = 0; i < TLBNUM; i++) begin
            write_entry(tlb_idx_t'(i), rand_entry(rand_ps()));
        end
    endtask

    // port 0 aims at the entry being read and port 1 is random
    task automatic read_all();
        for (int i = 0; i < TLBNUM; i++) begin
            r_index     = tlb_idx_t'(i);
            s0_vppn     = model_tlb[i].vppn;
            s0_va_bit12 = 1'($urandom);
            s0_asid     = model_tlb[i].asid;
            s1_vppn     = vppn_t'($urandom_range(0, 2047));
            s1_va_bit12 = 1'($urandom);
            s1_asid     = asid_t'($urandom_range(0, 3));
            wait_falls(1);
        end
    endtask

    initial begin
        tlb_entry_t ent;
        tlb_idx_t   lo;
        tlb_idx_t   hi;
        vppn_t      va;
        void'($urandom(32'h869d_ea8b));
        errors       = 0;
        checks       = 0;
        check_en     = 1'b0;
        arst_n       = 1'b0;
        we           = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        inv_asid     = '0;
        inv_vppn     = '0;
        drive_search('0, 1'b0, '0);
        model_reset();
        wait_falls(4);
        arst_n   = 1'b1;
        check_en = 1'b1;

        repeat (8) search_both(vppn_t'($urandom), 1'($urandom), asid_t'($urandom));
        read_all();

        // 4K entry searched during and after the write
        lo    = tlb_idx_t'($urandom);
        ent   = rand_entry(PS_4K);
        ent.g = 1'b0;
        drive_search(ent.vppn, 1'b0, ent.asid);
        write_entry(lo, ent);
        search_both(ent.vppn, 1'b0, ent.asid);
        search_both(ent.vppn, 1'b1, ent.asid);
        search_both(ent.vppn, 1'b1, ent.asid ^ 10'd1);
        ent.g = 1'b1;
        write_entry(lo, ent);
        search_both(ent.vppn, 1'b0, ent.asid ^ 10'd1);

        // 4M entry ignores vppn[8:0] for the match
        ent = rand_entry(PS_4M);
        write_entry(tlb_idx_t'($urandom), ent);
        repeat (8) begin
            va       = vppn_t'($urandom);
            va[18:9] = ent.vppn[18:9];
            search_both(va, 1'($urandom), ent.asid);
        end

        fill_all();
        read_all();

        for (int op = 0; op < 8; op++) begin
            fill_all();
            ent = model_tlb[$urandom_range(0, TLBNUM - 1)];
            invalidate((op == 7) ? invtlb_op_t'($urandom_range(7, 31)) : invtlb_op_t'(op),
                       ent.asid, ent.vppn);
            read_all();
        end

        // duplicate entries report the lowest index
        lo  = tlb_idx_t'($urandom_range(0, TLBNUM - 2));
        hi  = tlb_idx_t'($urandom_range(int'(lo) + 1, TLBNUM - 1));
        ent = rand_entry(rand_ps());
        write_entry(hi, ent);
        search_both(ent.vppn, 1'b1, ent.asid);
        write_entry(lo, ent);
        search_both(ent.vppn, 1'b0, ent.asid);

        // invalidate all with a write in the same cycle
        fill_all();
        we           = 1'b1;
        w_index      = lo;
        w_entry      = rand_entry(rand_ps());
        invtlb_valid = 1'b1;
        invtlb_op    = 5'd0;
        wait_falls(1);
        we           = 1'b0;
        invtlb_valid = 1'b0;
        read_all();

        wait_falls(2);
        check_en = 1'b0;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tlb_top.f ====
+incdir+tests
src/tlb_pkg.sv
src/tlb_entry_array.sv
src/tlb_search.sv
src/tlb_maint_ctrl.sv
src/tlb_top.sv
tests/tlb_top_tb.sv
